// File: sources.f
pm_pkg.sv
mem_bus_if.sv
w_bus_if.sv
univib.sv
pm.sv
panel.sv
bus_arbiter.sv
regs.sv
mem.sv
cpu_top.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: pm_slice

sources:
  - pm_pkg.sv
  - mem_bus_if.sv
  - w_bus_if.sv
  - univib.sv
  - pm.sv
  - panel.sv
  - bus_arbiter.sv
  - regs.sv
  - mem.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu.sv

// File: tb_cpu.sv
// Testbench for cpu_top. Programs go in through panel stores, results come
// back through panel fetches and are compared with a reference model.
// Memory and registers carry over from test to test, in the DUT and the model.
// irq is raised once ic shows the chosen instruction address and dropped once
// ic shows the interrupt vector, so each irq test takes exactly one interrupt.
// stop_sw stays low for the whole run.
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 1ps;
	import pm_pkg::*;

	localparam int n_tests = 5;
	localparam int max_words = 16;
	localparam int max_checks = 6;

	logic              clk;
	logic              rst_n;
	panel_op_t         panel_op;
	logic [word_w-1:0] panel_addr;
	logic [word_w-1:0] panel_data;
	logic              panel_stb;
	logic [word_w-1:0] panel_rdata;
	logic              panel_done;
	logic              start_sw;
	logic              stop_sw;
	logic              irq;
	logic              run;
	logic              wait_;
	logic [word_w-1:0] ic;

	// test table, expected values filled in by the model
	string             t_name [n_tests];
	int                t_words [n_tests];
	logic [word_w-1:0] t_addr [n_tests][max_words];
	logic [word_w-1:0] t_data [n_tests][max_words];
	logic [word_w-1:0] t_start [n_tests];
	int                t_irq [n_tests];
	int                t_checks [n_tests];
	logic [word_w-1:0] t_caddr [n_tests][max_checks];
	logic [word_w-1:0] t_cexp [n_tests][max_checks];
	logic [word_w-1:0] t_ic_exp [n_tests];

	// reference model state
	logic [word_w-1:0] mm [256];
	logic [word_w-1:0] mr [8];

	int seed = 45112;
	int errors = 0;
	int checks = 0;
	int done_seen = 0;
	int ops_issued = 0;
	int limit = 0;
	int cycles = 0;

	cpu_top i_dut (
		.__clk      (clk),
		.rst_n      (rst_n),
		.panel_op   (panel_op),
		.panel_addr (panel_addr),
		.panel_data (panel_data),
		.panel_stb  (panel_stb),
		.panel_rdata(panel_rdata),
		.panel_done (panel_done),
		.start_sw   (start_sw),
		.stop_sw    (stop_sw),
		.irq        (irq),
		.run        (run),
		.wait_      (wait_),
		.ic         (ic)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (panel_done)
			done_seen <= done_seen + 1;
	end

	// watchdog over the whole run
	initial begin
		#1;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("test failed");
		$finish;
	end

	function automatic logic [word_w-1:0] imm_word(input logic [5:0] op, input logic [2:0] a,
			input logic [6:0] t);
		return {op, a, t};
	endfunction

	function automatic logic [word_w-1:0] norm_word(input logic [5:0] op, input logic [2:0] a,
			input logic [2:0] b);
		return {op, 1'b0, a, b, 3'b000};
	endfunction

	function automatic logic [word_w-1:0] sext7(input logic [6:0] t);
		return {{(word_w - 7){t[6]}}, t};
	endfunction

	task automatic new_test(input int ti, input string name, input logic [word_w-1:0] start,
			input int irq_at);
		t_name[ti] = name;
		t_start[ti] = start;
		t_irq[ti] = irq_at;
		t_words[ti] = 0;
		t_checks[ti] = 0;
	endtask

	task automatic put_word(input int ti, input logic [word_w-1:0] addr,
			input logic [word_w-1:0] data);
		t_addr[ti][t_words[ti]] = addr;
		t_data[ti][t_words[ti]] = data;
		t_words[ti] = t_words[ti] + 1;
	endtask

	task automatic put_check(input int ti, input logic [word_w-1:0] addr);
		t_caddr[ti][t_checks[ti]] = addr;
		t_checks[ti] = t_checks[ti] + 1;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		new_test(0, "panel_path", 16'h0030, -1);
		for (int k = 0; k < 4; k++) begin
			rnd = $random(seed);
			put_word(0, 16'h00f0 + 16'(k), rnd[15:0]);
			put_check(0, 16'h00f0 + 16'(k));
		end
		put_word(0, 16'h0030, norm_word(op_hlt, 3'd0, 3'd0));

		// negative constants included
		rnd = $random(seed);
		new_test(1, "lwt_rw", 16'h0040, -1);
		put_word(1, 16'h0040, imm_word(op_lwt, 3'd1, rnd[6:0]));
		put_word(1, 16'h0041, imm_word(op_lwt, 3'd2, 7'h7b));
		put_word(1, 16'h0042, norm_word(op_rw, 3'd1, 3'd0));
		put_word(1, 16'h0043, 16'h00e0);
		put_word(1, 16'h0044, norm_word(op_rw, 3'd2, 3'd0));
		put_word(1, 16'h0045, 16'h00e1);
		put_word(1, 16'h0046, imm_word(op_lwt, 3'd3, 7'h40));
		put_word(1, 16'h0047, norm_word(op_rw, 3'd3, 3'd0));
		put_word(1, 16'h0048, 16'h00e2);
		put_word(1, 16'h0049, norm_word(op_hlt, 3'd0, 3'd0));
		put_check(1, 16'h00e0);
		put_check(1, 16'h00e1);
		put_check(1, 16'h00e2);

		// -5 plus -64 carries out of bit 15
		rnd = $random(seed);
		new_test(2, "aw_wrap", 16'h0050, -1);
		put_word(2, 16'h0050, imm_word(op_lwt, 3'd4, 7'h7b));
		put_word(2, 16'h0051, imm_word(op_lwt, 3'd5, 7'h40));
		put_word(2, 16'h0052, norm_word(op_aw, 3'd4, 3'd5));
		put_word(2, 16'h0053, norm_word(op_rw, 3'd4, 3'd0));
		put_word(2, 16'h0054, 16'h00e3);
		put_word(2, 16'h0055, imm_word(op_lwt, 3'd6, rnd[6:0]));
		put_word(2, 16'h0056, norm_word(op_aw, 3'd6, 3'd4));
		put_word(2, 16'h0057, norm_word(op_rw, 3'd6, 3'd0));
		put_word(2, 16'h0058, 16'h00e4);
		put_word(2, 16'h0059, norm_word(op_hlt, 3'd0, 3'd0));
		put_check(2, 16'h00e3);
		put_check(2, 16'h00e4);

		// jump over the first RW, its target keeps the preset word
		new_test(3, "ujs_hlt", 16'h0060, -1);
		put_word(3, 16'h00e5, 16'h5a5a);
		put_word(3, 16'h0060, imm_word(op_lwt, 3'd1, 7'd7));
		put_word(3, 16'h0061, imm_word(op_ujs, 3'd0, 7'd2));
		put_word(3, 16'h0062, norm_word(op_rw, 3'd1, 3'd0));
		put_word(3, 16'h0063, 16'h00e5);
		put_word(3, 16'h0064, norm_word(op_rw, 3'd1, 3'd0));
		put_word(3, 16'h0065, 16'h00e6);
		put_word(3, 16'h0066, norm_word(op_hlt, 3'd0, 3'd0));
		put_check(3, 16'h00e5);
		put_check(3, 16'h00e6);

		// interrupt at the boundary before 0x73, handler halts
		new_test(4, "irq", 16'h0070, 'h73);
		put_word(4, 16'h00e9, 16'h1234);
		put_word(4, 16'h0070, imm_word(op_lwt, 3'd2, 7'd3));
		put_word(4, 16'h0071, norm_word(op_rw, 3'd2, 3'd0));
		put_word(4, 16'h0072, 16'h00e7);
		put_word(4, 16'h0073, imm_word(op_lwt, 3'd2, 7'd9));
		put_word(4, 16'h0074, norm_word(op_rw, 3'd2, 3'd0));
		put_word(4, 16'h0075, 16'h00e9);
		put_word(4, 16'h0076, norm_word(op_hlt, 3'd0, 3'd0));
		put_word(4, int_vector, imm_word(op_lwt, 3'd7, 7'h2a));
		put_word(4, int_vector + 16'd1, norm_word(op_rw, 3'd7, 3'd0));
		put_word(4, int_vector + 16'd2, 16'h00e8);
		put_word(4, int_vector + 16'd3, norm_word(op_hlt, 3'd0, 3'd0));
		put_check(4, int_save_addr);
		put_check(4, 16'h00e7);
		put_check(4, 16'h00e8);
		put_check(4, 16'h00e9);
	endtask

	// runs one test program on the model memory and registers
	task automatic model_run(input int ti);
		logic [word_w-1:0] mic;
		logic [word_w-1:0] iw;
		logic [word_w-1:0] adr;
		logic [5:0]        op;
		bit                taken;
		bit                halted;
		int                steps;
		for (int j = 0; j < t_words[ti]; j++)
			mm[t_addr[ti][j][7:0]] = t_data[ti][j];
		mic = t_start[ti];
		taken = 0;
		halted = 0;
		steps = 0;
		while (!halted && steps < 200) begin
			if (t_irq[ti] >= 0 && !taken && int'(mic) == t_irq[ti]) begin
				mm[int_save_addr[7:0]] = mic;
				mic = int_vector;
				taken = 1;
			end
			iw = mm[mic[7:0]];
			mic = mic + 1'b1;
			op = iw[15:10];
			if (op == op_lwt) begin
				mr[iw[9:7]] = sext7(iw[6:0]);
			end else if (op == op_aw) begin
				mr[iw[8:6]] = mr[iw[8:6]] + mr[iw[5:3]];
			end else if (op == op_rw) begin
				adr = mm[mic[7:0]];
				mic = mic + 1'b1;
				mm[adr[7:0]] = mr[iw[8:6]];
			end else if (op == op_ujs) begin
				mic = mic + sext7(iw[6:0]);
			end else if (op == op_hlt) begin
				halted = 1;
			end
			steps++;
		end
		if (!halted) begin
			errors++;
			$display("model of test %s never reached HLT", t_name[ti]);
		end
		for (int k = 0; k < t_checks[ti]; k++)
			t_cexp[ti][k] = mm[t_caddr[ti][k][7:0]];
		t_ic_exp[ti] = mic;
	endtask

	task automatic panel_cycle(input panel_op_t op, input logic [word_w-1:0] addr,
			input logic [word_w-1:0] data, output logic [word_w-1:0] rdata);
		@(posedge clk);
		panel_op <= op;
		panel_addr <= addr;
		panel_data <= data;
		panel_stb <= 1'b1;
		@(posedge clk);
		panel_stb <= 1'b0;
		do
			@(posedge clk);
		while (!panel_done);
		rdata = panel_rdata;
		ops_issued++;
	endtask

	task automatic check_word(input string name, input logic [word_w-1:0] exp,
			input logic [word_w-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	initial begin
		logic [word_w-1:0] rd;
		int                total;
		bit                taken;
		rst_n = 1'b0;
		panel_op = panel_none;
		panel_addr = '0;
		panel_data = '0;
		panel_stb = 1'b0;
		start_sw = 1'b0;
		stop_sw = 1'b0;
		irq = 1'b0;
		for (int k = 0; k < 8; k++)
			mr[k] = '0;
		build_table();
		total = 0;
		for (int i = 0; i < n_tests; i++)
			total += t_words[i];
		limit = total * 40 + 1000;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_word("reset run", 16'h0, {15'h0, run});
		check_word("reset wait_", 16'h1, {15'h0, wait_});
		check_word("reset panel_done", 16'h0, {15'h0, panel_done});
		check_word("reset ic", 16'h0, ic);

		for (int i = 0; i < n_tests; i++) begin
			model_run(i);
			for (int j = 0; j < t_words[i]; j++)
				panel_cycle(panel_store, t_addr[i][j], t_data[i][j], rd);
			panel_cycle(panel_load, t_start[i], t_start[i], rd);
			check_word({t_name[i], " load"}, t_start[i], ic);

			@(posedge clk);
			start_sw <= 1'b1;
			@(posedge clk);
			start_sw <= 1'b0;
			do
				@(posedge clk);
			while (!run);

			// irq follows the instruction position seen on ic
			taken = 0;
			while (run) begin
				if (t_irq[i] >= 0 && !taken && !irq && int'(ic) == t_irq[i])
					irq <= 1'b1;
				if (irq && ic == int_vector) begin
					irq <= 1'b0;
					taken = 1;
				end
				@(posedge clk);
			end
			irq <= 1'b0;

			// a halted machine stays put past one more KC and PC
			repeat (kc_ticks + pc_ticks + 4) @(posedge clk);
			check_word({t_name[i], " run"}, 16'h0, {15'h0, run});
			check_word({t_name[i], " wait_"}, 16'h0, {15'h0, wait_});
			check_word({t_name[i], " ic"}, t_ic_exp[i], ic);
			for (int k = 0; k < t_checks[i]; k++) begin
				panel_cycle(panel_fetch, t_caddr[i][k], '0, rd);
				check_word($sformatf("%s @%h", t_name[i], t_caddr[i][k]), t_cexp[i][k], rd);
			end
		end

		@(posedge clk);
		check_word("panel_done count", 16'(ops_issued), 16'(done_seen));
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_top.sv
// Top level of the pm slice. Panel and pm share one memory through the arbiter.
// start_sw and panel_stb are one-clock strobes. stop_sw and irq are levels.
`default_nettype none

module cpu_top (
	input  logic                      __clk,
	input  logic                      rst_n,
	input  pm_pkg::panel_op_t         panel_op,
	input  logic [pm_pkg::word_w-1:0] panel_addr,
	input  logic [pm_pkg::word_w-1:0] panel_data,
	input  logic                      panel_stb,
	output logic [pm_pkg::word_w-1:0] panel_rdata,
	output logic                      panel_done,
	input  logic                      start_sw,
	input  logic                      stop_sw,
	input  logic                      irq,
	output logic                      run,
	output logic                      wait_,
	output logic [pm_pkg::word_w-1:0] ic
);

	logic load_ic_stb;

	mem_bus_if bus_cpu ();
	mem_bus_if bus_panel ();
	mem_bus_if bus_mem ();
	w_bus_if   wbus ();

	// the panel holds the load value on its wdata lines
	pm i_pm (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.start_sw   (start_sw),
		.stop_sw    (stop_sw),
		.irq        (irq),
		.load_ic_stb(load_ic_stb),
		.load_ic_val(bus_panel.wdata),
		.run        (run),
		.wait_      (wait_),
		.ic         (ic),
		.bus        (bus_cpu.requester),
		.wb         (wbus.master)
	);

	panel i_panel (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.panel_op   (panel_op),
		.panel_addr (panel_addr),
		.panel_data (panel_data),
		.panel_stb  (panel_stb),
		.panel_rdata(panel_rdata),
		.panel_done (panel_done),
		.load_ic_stb(load_ic_stb),
		.bus        (bus_panel.requester)
	);

	bus_arbiter i_arb (
		.__clk  (__clk),
		.rst_n  (rst_n),
		.p_panel(bus_panel.arbiter),
		.p_cpu  (bus_cpu.arbiter),
		.m      (bus_mem.source)
	);

	regs i_regs (
		.__clk(__clk),
		.rst_n(rst_n),
		.wb   (wbus.slave)
	);

	mem i_mem (
		.__clk(__clk),
		.bus  (bus_mem.memory)
	);

endmodule

`default_nettype wire

// File: mem.sv
// 256-word synchronous memory on the shared bus.
// Only addr[addr_w-1:0] is decoded. Contents start undefined.
// Read data and rd_stb come one clock after the grant.
`default_nettype none

module mem (
	input logic        __clk,
	mem_bus_if.memory  bus
);
	import pm_pkg::*;

	logic [word_w-1:0] ram [0:(1 << addr_w) - 1];
	logic              access;

	assign access = bus.gnt && bus.req;

	always_ff @(posedge __clk) begin
		bus.rd_stb <= access && !bus.we;
		if (access && bus.we)
			ram[bus.addr[addr_w-1:0]] <= bus.wdata;
		if (access && !bus.we)
			bus.rdata <= ram[bus.addr[addr_w-1:0]];
	end

endmodule

`default_nettype wire

// File: regs.sv
// Eight general registers with the AW adder on the write path.
// Sums wrap modulo 2^16. Writes land one clock after w_r.
`default_nettype none

module regs (
	input  logic    __clk,
	input  logic    rst_n,
	w_bus_if.slave  wb
);
	import pm_pkg::*;

	logic [word_w-1:0] r [8];
	logic [word_w-1:0] sum;

	assign wb.ra_val = r[wb.sel_a];
	assign wb.rb_val = r[wb.sel_b];
	assign sum = wb.ra_val + wb.rb_val;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				r[i] <= '0;
		end else if (wb.w_r) begin
			// add picks a+b over the W bus value
			r[wb.sel_a] <= wb.add ? sum : wb.w;
		end
	end

endmodule

`default_nettype wire

// File: bus_arbiter.sv
// Fixed priority arbiter for the memory bus. The panel wins over pm.
// One transaction at a time. No new grant until the read data is back.
`default_nettype none

module bus_arbiter (
	input  logic        __clk,
	input  logic        rst_n,
	mem_bus_if.arbiter  p_panel,
	mem_bus_if.arbiter  p_cpu,
	mem_bus_if.source   m
);

	logic gnt_q;
	logic own_panel;
	logic rd_pend;
	logic idle;

	assign idle = !gnt_q && !rd_pend;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_q <= 1'b0;
			own_panel <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			gnt_q <= 1'b0;
			if (m.rd_stb)
				rd_pend <= 1'b0;
			if (idle && p_panel.req) begin
				gnt_q <= 1'b1;
				own_panel <= 1'b1;
				rd_pend <= !p_panel.we;
			end else if (idle && p_cpu.req) begin
				gnt_q <= 1'b1;
				own_panel <= 1'b0;
				rd_pend <= !p_cpu.we;
			end
		end
	end

	// owner stays selected until its read strobe
	assign m.req = own_panel ? p_panel.req : p_cpu.req;
	assign m.we = own_panel ? p_panel.we : p_cpu.we;
	assign m.addr = own_panel ? p_panel.addr : p_cpu.addr;
	assign m.wdata = own_panel ? p_panel.wdata : p_cpu.wdata;
	assign m.gnt = gnt_q;

	assign p_panel.gnt = gnt_q & own_panel;
	assign p_cpu.gnt = gnt_q & ~own_panel;
	assign p_panel.rdata = m.rdata;
	assign p_cpu.rdata = m.rdata;
	assign p_panel.rd_stb = m.rd_stb & own_panel;
	assign p_cpu.rd_stb = m.rd_stb & ~own_panel;

endmodule

`default_nettype wire

// File: panel.sv
// Control panel. Turns operator FETCH, STORE and LOAD into cycles.
// One request at a time. panel_stb while busy is dropped.
// LOAD hands panel_data to pm through bus.wdata with load_ic_stb.
`default_nettype none

module panel (
	input  logic                      __clk,
	input  logic                      rst_n,
	input  pm_pkg::panel_op_t         panel_op,
	input  logic [pm_pkg::word_w-1:0] panel_addr,
	input  logic [pm_pkg::word_w-1:0] panel_data,
	input  logic                      panel_stb,
	output logic [pm_pkg::word_w-1:0] panel_rdata,
	output logic                      panel_done,
	output logic                      load_ic_stb,
	mem_bus_if.requester              bus
);
	import pm_pkg::*;

	logic busy;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			bus.req <= 1'b0;
			bus.we <= 1'b0;
			bus.addr <= '0;
			bus.wdata <= '0;
			panel_rdata <= '0;
			panel_done <= 1'b0;
			load_ic_stb <= 1'b0;
		end else begin
			panel_done <= 1'b0;
			load_ic_stb <= 1'b0;
			if (panel_stb && !busy) begin
				case (panel_op)
				panel_fetch: begin
					busy <= 1'b1;
					bus.req <= 1'b1;
					bus.we <= 1'b0;
					bus.addr <= panel_addr;
				end
				panel_store: begin
					busy <= 1'b1;
					bus.req <= 1'b1;
					bus.we <= 1'b1;
					bus.addr <= panel_addr;
					bus.wdata <= panel_data;
				end
				panel_load: begin
					// no bus cycle, value goes straight to ic
					busy <= 1'b1;
					bus.wdata <= panel_data;
					load_ic_stb <= 1'b1;
				end
				default: ;
				endcase
			end
			if (bus.gnt) begin
				bus.req <= 1'b0;
				// a store is finished at the grant
				if (bus.we) begin
					panel_done <= 1'b1;
					busy <= 1'b0;
				end
			end
			if (bus.rd_stb) begin
				panel_rdata <= bus.rdata;
				panel_done <= 1'b1;
				busy <= 1'b0;
			end
			if (load_ic_stb) begin
				panel_done <= 1'b1;
				busy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: pm.sv
// Cycle control: START, WAIT and RUN, then KC and PC, then the P0..P5 steps.
// No modification states, no group or step counters, no byte addressing.
// Interrupt receive needs irq and START. It is not masked and not acknowledged.
// Unknown opcodes run as no-ops. load_ic_stb overrides ic in any state,
// so load only while the machine is stopped.
`default_nettype none

module pm (
	input  logic                      __clk,
	input  logic                      rst_n,
	input  logic                      start_sw,
	input  logic                      stop_sw,
	input  logic                      irq,
	input  logic                      load_ic_stb,
	input  logic [pm_pkg::word_w-1:0] load_ic_val,
	output logic                      run,
	output logic                      wait_,
	output logic [pm_pkg::word_w-1:0] ic,
	mem_bus_if.requester              bus,
	w_bus_if.master                   wb
);
	import pm_pkg::*;

	logic              start_q;
	logic              wait_q;
	logic              pr;
	logic              przerw;
	logic              cyc;
	logic [2:0]        state;
	instr_t            ir;
	logic              kc_q;
	logic              kc_d;
	logic              pc_q;
	logic              pc_d;
	logic              kc_trig;
	logic              pc_end;
	logic              dprzerw;
	logic [word_w-1:0] t_ext;

	assign run = start_q & ~wait_q;
	assign wait_ = ~wait_q;

	// new cycle once back in P0
	assign kc_trig = run && (state == st_p0) && !cyc;

	univib #(.ticks(kc_ticks)) vib_kc (
		.__clk(__clk),
		.rst_n(rst_n),
		.trig (kc_trig),
		.q    (kc_q)
	);

	// PC starts on the falling edge of KC
	univib #(.ticks(pc_ticks)) vib_pc (
		.__clk(__clk),
		.rst_n(rst_n),
		.trig (kc_d & ~kc_q),
		.q    (pc_q)
	);

	assign pc_end = pc_d & ~pc_q;
	assign dprzerw = irq && start_q && !pr;
	assign t_ext = {{(word_w - 7){ir.imm.t[6]}}, ir.imm.t};

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
			wait_q <= 1'b0;
			pr <= 1'b0;
			przerw <= 1'b0;
			cyc <= 1'b0;
			state <= st_p0;
			ir <= '0;
			ic <= '0;
			kc_d <= 1'b0;
			pc_d <= 1'b0;
			bus.req <= 1'b0;
			bus.we <= 1'b0;
			bus.addr <= '0;
			bus.wdata <= '0;
			wb.w_r <= 1'b0;
			wb.sel_a <= '0;
			wb.sel_b <= '0;
			wb.w <= '0;
			wb.add <= 1'b0;
		end else begin
			kc_d <= kc_q;
			pc_d <= pc_q;
			wb.w_r <= 1'b0;
			if (bus.gnt)
				bus.req <= 1'b0;
			if (stop_sw)
				start_q <= 1'b0;
			else if (start_sw)
				start_q <= 1'b1;
			if (start_sw)
				wait_q <= 1'b0;
			if (kc_trig)
				cyc <= 1'b1;

			case (state)
			st_p0: begin
				if (pc_end) begin
					cyc <= 1'b0;
					if (dprzerw) begin
						// interrupt receive, save ic first
						przerw <= 1'b1;
						bus.req <= 1'b1;
						bus.we <= 1'b1;
						bus.addr <= int_save_addr;
						bus.wdata <= ic;
						state <= st_p1;
					end else if (run) begin
						pr <= 1'b1;
						bus.req <= 1'b1;
						bus.we <= 1'b0;
						bus.addr <= ic;
						state <= st_p1;
					end
				end
			end
			st_p1: begin
				if (przerw && bus.gnt) begin
					ic <= int_vector;
					state <= st_p5;
				end else if (pr && bus.rd_stb) begin
					ir <= bus.rdata;
					ic <= ic + 1'b1;
					state <= st_p2;
				end
			end
			st_p2: begin
				state <= st_p5;
				case (ir.norm.opcode)
				op_lwt: begin
					wb.sel_a <= ir.imm.a;
					wb.w <= t_ext;
					wb.add <= 1'b0;
					wb.w_r <= 1'b1;
				end
				op_aw: begin
					wb.sel_a <= ir.norm.a;
					wb.sel_b <= ir.norm.b;
					wb.add <= 1'b1;
					wb.w_r <= 1'b1;
				end
				op_rw: begin
					// address comes in the next word
					wb.sel_a <= ir.norm.a;
					bus.req <= 1'b1;
					bus.we <= 1'b0;
					bus.addr <= ic;
					state <= st_p3;
				end
				op_ujs: ic <= ic + t_ext;
				op_hlt: wait_q <= 1'b1;
				default: ;
				endcase
			end
			st_p3: begin
				if (bus.rd_stb) begin
					ic <= ic + 1'b1;
					bus.req <= 1'b1;
					bus.we <= 1'b1;
					bus.addr <= bus.rdata;
					bus.wdata <= wb.ra_val;
					state <= st_p4;
				end
			end
			st_p4: begin
				if (bus.gnt)
					state <= st_p5;
			end
			st_p5: begin
				pr <= 1'b0;
				przerw <= 1'b0;
				state <= st_p0;
			end
			default: state <= st_p0;
			endcase

			if (load_ic_stb)
				ic <= load_ic_val;
		end
	end

endmodule

`default_nettype wire

// File: univib.sv
// One-shot timer. q stays high for exactly ticks clocks after trig.
// A trig that arrives while q is high is ignored, no retrigger.
// ticks must be at least 1.
`default_nettype none

module univib #(
	parameter int ticks = 1
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic trig,
	output logic q
);

	logic [$clog2(ticks + 1)-1:0] cnt;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			if (trig)
				cnt <= ticks[$clog2(ticks + 1)-1:0];
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign q = (cnt != '0);

endmodule

`default_nettype wire

// File: w_bus_if.sv
// Register write and read path between pm and the register file.
// w_r is a one-clock strobe. Reads of ra_val and rb_val are combinational.
`default_nettype none

interface w_bus_if;
	import pm_pkg::*;

	logic              w_r;
	logic [2:0]        sel_a;
	logic [2:0]        sel_b;
	logic [word_w-1:0] w;
	logic              add;
	logic [word_w-1:0] ra_val;
	logic [word_w-1:0] rb_val;

	modport master (output w_r, sel_a, sel_b, w, add, input ra_val, rb_val);
	modport slave (input w_r, sel_a, sel_b, w, add, output ra_val, rb_val);

endinterface

`default_nettype wire

// File: mem_bus_if.sv
// Shared memory bus between the requesters, the arbiter and the memory.
// req is a level held until gnt. gnt and rd_stb are one-clock strobes.
// rd_stb comes exactly one clock after the grant of a read.
`default_nettype none

interface mem_bus_if;
	import pm_pkg::*;

	logic              req;
	logic              we;
	logic [word_w-1:0] addr;
	logic [word_w-1:0] wdata;
	logic              gnt;
	logic [word_w-1:0] rdata;
	logic              rd_stb;

	// pm and panel side
	modport requester (output req, we, addr, wdata, input gnt, rdata, rd_stb);
	// arbiter facing one requester
	modport arbiter (input req, we, addr, wdata, output gnt, rdata, rd_stb);
	// arbiter driving the memory
	modport source (output req, we, addr, wdata, gnt, input rdata, rd_stb);
	modport memory (input req, we, addr, wdata, gnt, output rdata, rd_stb);

endinterface

`default_nettype wire

// File: pm_pkg.sv
// Shared constants and types for the pm cycle-control slice.
// Only the low addr_w address bits reach the memory. Higher bits alias.
// Opcodes sit in the top 6 bits of every instruction word.
// The immediate form is used by LWT and UJS. All others use the normal form.
`default_nettype none

package pm_pkg;

	localparam int word_w = 16;
	localparam int addr_w = 8;

	// interrupt receive
	localparam logic [word_w-1:0] int_save_addr = 16'h0010;
	localparam logic [word_w-1:0] int_vector = 16'h0020;

	// one-shot lengths in clocks
	localparam int kc_ticks = 3;
	localparam int pc_ticks = 2;

	localparam logic [5:0] op_lwt = 6'o45;
	localparam logic [5:0] op_aw = 6'o31;
	localparam logic [5:0] op_rw = 6'o24;
	localparam logic [5:0] op_ujs = 6'o70;
	localparam logic [5:0] op_hlt = 6'o73;

	// sequencer states
	localparam logic [2:0] st_p0 = 3'd0;
	localparam logic [2:0] st_p1 = 3'd1;
	localparam logic [2:0] st_p2 = 3'd2;
	localparam logic [2:0] st_p3 = 3'd3;
	localparam logic [2:0] st_p4 = 3'd4;
	localparam logic [2:0] st_p5 = 3'd5;

	// one instruction word, seen in two ways
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic       d;
			logic [2:0] a;
			logic [2:0] b;
			logic [2:0] c;
		} norm;
		struct packed {
			logic [5:0]        opcode;
			logic [2:0]        a;
			logic signed [6:0] t;
		} imm;
	} instr_t;

	typedef enum logic [1:0] {
		panel_none,
		panel_fetch,
		panel_store,
		panel_load
	} panel_op_t;

endpackage

`default_nettype wire
